// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int MAX_CYCLES = 200;            // Cycle limit given to the DUT
    localparam int ACK_LIMIT  = 400;            // Wait budget in clocks

    logic   clk;
    logic   reset;
    logic   start;
    logic   prog_we;
    pc_t    prog_addr;
    instr_t prog_data;
    logic   ack;
    logic   timeout;
    data_t  result;                             // r1

    instr_t prog [$];                           // Program under test
    int     errors;                             // Failed checks
    int     checks;                             // All checks
    int     hangs;                              // Waits that ran out
    int     ack_cycles;                         // Clocks from start release to ack
    data_t  exp_r1;                             // Model prediction
    bit     exp_timeout;                        // Model stop reason

    cpu_top #(
        .MAX_CYCLES (MAX_CYCLES),
        .PROG_DEPTH (256),
        .DMEM_DEPTH (256)
    ) i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ack       (ack),
        .timeout   (timeout),
        .result    (result)
    );

    always #2 clk = ~clk;                       // 4 ns period

    // Instruction encoders
    function automatic instr_t ldi_word(data_t value);
        return {1'b1, value};                   // r1 = value
    endfunction

    function automatic instr_t rr_word(opcode_t op, reg_idx_t ra, reg_idx_t rb);
        return {1'b0, op, ra, rb, 1'b0};
    endfunction

    function automatic instr_t branch_word(logic [3:0] offset);
        return {1'b0, CTRL, offset, 1'b0};      // BZ with offset in bits 4..1
    endfunction

    function automatic instr_t halt_word();
        return {1'b0, CTRL, 4'b0000, 1'b1};     // DONE
    endfunction

    // r1 into another register through dmem[r0]
    task automatic copy_r1_to(reg_idx_t dst);
        prog.push_back(rr_word(STORE, 2'd0, 2'd1));
        prog.push_back(rr_word(LOAD, 2'd0, dst));
    endtask

    // ISA interpreter over prog
    task automatic predict(output data_t r1_out, output bit hit_limit);
        data_t    regs [4];
        data_t    mem [256];
        pc_t      pc;
        instr_t   word;
        opcode_t  op;
        data_t    a;
        data_t    b;
        bit       halted;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        pc     = '0;
        halted = 1'b0;
        for (int n = 0; n < MAX_CYCLES && !halted; n++) begin
            if (int'(pc) >= prog.size()) begin
                $display("reference model ran past the end of the program at pc %0d", pc);
                errors++;
                halted = 1'b1;
            end else begin
                word = prog[pc];
                op   = opcode_t'(word[7:5]);
                a    = regs[word[4:3]];
                b    = regs[word[2:1]];
                pc   = pc + 8'd1;               // Default next word
                if (word[8]) begin
                    regs[1] = word[7:0];        // LDI
                end else begin
                    case (op)
                        ADD:   if (word[4:1] != 4'd0) regs[1] = a + b;  // r0,r0 is NOP
                        SUB:   regs[1] = a - b;
                        AND:   regs[1] = a & b;
                        XOR:   regs[1] = a ^ b;
                        SHL:   regs[1] = a << b[2:0];
                        LOAD:  regs[word[2:1]] = mem[a];
                        STORE: mem[a] = b;
                        default: begin
                            if (word[0]) begin
                                halted = 1'b1;  // DONE
                            end else if (regs[1] == 8'd0) begin
                                pc = pc_t'(int'(pc) - 1 + int'($signed(word[4:1])));
                            end
                        end
                    endcase
                end
            end
        end
        r1_out    = regs[1];
        hit_limit = !halted;                    // Limit reached before DONE
    endtask

    task automatic compare(string what, data_t got, data_t want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("error %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);              // Four cycles
        reset = 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // DUT must stay idle while start is high
    task automatic pulse_start(int hold);
        @(negedge clk);
        start = 1'b1;
        repeat (hold) begin
            @(negedge clk);
            compare("result while start high", result, 8'd0);
            compare("ack while start high", data_t'(ack), 8'd0);
        end
        start = 1'b0;                           // Run begins after this
    endtask

    task automatic wait_ack(output bit seen);
        int n;
        n = 0;
        while (!ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        seen       = ack;
        ack_cycles = n;
        if (!seen) begin
            hangs++;
            $display("ack did not rise within %0d cycles at time %0t", ACK_LIMIT, $time);
        end
    endtask

    task automatic run_and_check(string name, int hold, output bit seen);
        predict(exp_r1, exp_timeout);
        reset_dut();
        load_program();
        pulse_start(hold);
        wait_ack(seen);
        if (seen) begin
            compare({name, " result"}, result, exp_r1);
            compare({name, " timeout"}, data_t'(timeout), data_t'(exp_timeout));
        end
    endtask

    // Halted state must freeze until reset
    task automatic hold_after_halt();
        data_t held_result;
        logic  held_timeout;
        held_result  = result;
        held_timeout = timeout;
        repeat (20) begin
            @(negedge clk);
            compare("result after halt", result, held_result);
            compare("ack after halt", data_t'(ack), 8'd1);
            compare("timeout after halt", data_t'(timeout), data_t'(held_timeout));
        end
        reset_dut();
        compare("result after reset", result, 8'd0);
        compare("ack after reset", data_t'(ack), 8'd0);
        compare("timeout after reset", data_t'(timeout), 8'd0);
    endtask

    initial begin
        data_t a1;
        data_t a2;
        int    n;
        bit    seen;
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        errors     = 0;
        checks     = 0;
        hangs      = 0;
        ack_cycles = 0;
        void'($urandom(32'ha923));

        // Arithmetic chain
        repeat (4) begin
            prog.delete();
            prog.push_back(ldi_word(data_t'($urandom)));
            copy_r1_to(2'd2);
            prog.push_back(ldi_word(data_t'($urandom)));
            copy_r1_to(2'd3);
            prog.push_back(rr_word(ADD, 2'd2, 2'd3));
            prog.push_back(9'h000);             // NOP keeps r1
            prog.push_back(rr_word(SUB, 2'd1, 2'd3));
            prog.push_back(rr_word(XOR, 2'd1, 2'd2));
            prog.push_back(rr_word(AND, 2'd1, 2'd3));
            prog.push_back(rr_word(XOR, 2'd1, 2'd2));
            prog.push_back(rr_word(SHL, 2'd1, 2'd3));
            prog.push_back(halt_word());
            run_and_check("arith", 1, seen);
        end

        // Store two values and load both back
        repeat (3) begin
            a1 = data_t'(1 + $urandom % 255);   // Nonzero since dmem[0] is scratch
            a2 = data_t'(1 + $urandom % 255);
            prog.delete();
            prog.push_back(ldi_word(a1));
            copy_r1_to(2'd3);
            prog.push_back(ldi_word(data_t'($urandom)));
            prog.push_back(rr_word(STORE, 2'd3, 2'd1));
            prog.push_back(ldi_word(a2));
            copy_r1_to(2'd3);
            prog.push_back(ldi_word(data_t'($urandom)));
            prog.push_back(rr_word(STORE, 2'd3, 2'd1));
            prog.push_back(ldi_word(a1));
            copy_r1_to(2'd3);
            prog.push_back(rr_word(LOAD, 2'd3, 2'd2));
            prog.push_back(ldi_word(a2));
            copy_r1_to(2'd3);
            prog.push_back(rr_word(LOAD, 2'd3, 2'd3));
            prog.push_back(ldi_word(8'd0));
            prog.push_back(rr_word(XOR, 2'd2, 2'd3));
            prog.push_back(halt_word());
            run_and_check("memory", 1, seen);
        end

        // Countdown loop with r0 = 1, r2 as counter and r3 as sum
        n = 1 + int'($urandom % 15);
        prog.delete();
        prog.push_back(ldi_word(8'd1));
        copy_r1_to(2'd0);
        prog.push_back(ldi_word(data_t'(n)));
        copy_r1_to(2'd2);
        prog.push_back(rr_word(ADD, 2'd3, 2'd2));  // Loop top at 6
        copy_r1_to(2'd3);
        prog.push_back(rr_word(SUB, 2'd2, 2'd0));
        copy_r1_to(2'd2);
        prog.push_back(branch_word(4'd3));         // Exit when counter is 0
        prog.push_back(rr_word(SUB, 2'd2, 2'd2));  // Force r1 zero
        prog.push_back(branch_word(4'h8));         // Back to 6
        prog.push_back(rr_word(SUB, 2'd3, 2'd2));  // r1 = sum
        prog.push_back(halt_word());
        run_and_check("loop", 1, seen);
        if (seen) begin
            compare("loop sum", result, data_t'(n * (n + 1) / 2));
            hold_after_halt();
        end

        // Start held high for a while
        prog.delete();
        prog.push_back(ldi_word(data_t'($urandom) | 8'd1));
        prog.push_back(halt_word());
        run_and_check("start", 6, seen);

        // Endless loop hits the limit
        prog.delete();
        prog.push_back(ldi_word(8'd0));
        prog.push_back(branch_word(4'hf));         // Back one word
        run_and_check("limit", 1, seen);
        compare("limit prediction", data_t'(exp_timeout), 8'd1);
        if (seen) begin
            checks++;
            // Release edge leaves ARMED, then MAX_CYCLES RUN cycles
            assert (ack_cycles == MAX_CYCLES + 1) else begin
                errors++;
                $display("error %0t: limit ack after %0d clocks, expected %0d",
                         $time, ack_cycles, MAX_CYCLES + 1);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, hangs);
        if (errors == 0 && hangs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/register_file.sv
src/execute_unit.sv
src/result_unit.sv
src/run_control.sv
src/cpu_top.sv
bench/cpu_tb.sv

// File: src/cpu_pkg.sv
package cpu_pkg;

    // Word types
    typedef logic [8:0] instr_t;            // Full instruction word
    typedef logic [7:0] data_t;             // Register, memory and immediate width
    typedef logic [7:0] pc_t;               // Program counter and program address
    typedef logic [1:0] reg_idx_t;          // One of four registers

    // Opcode classes for bit 8 clear
    typedef enum logic [2:0] {
        ADD   = 3'd0,                       // r1 = r_a + r_b
        SUB   = 3'd1,                       // r1 = r_a - r_b
        AND   = 3'd2,                       // r1 = r_a & r_b
        XOR   = 3'd3,                       // r1 = r_a ^ r_b
        SHL   = 3'd4,                       // r1 = r_a << r_b[2:0]
        LOAD  = 3'd5,                       // r_b = dmem[r_a]
        STORE = 3'd6,                       // dmem[r_a] = r_b
        CTRL  = 3'd7                        // BZ or DONE, picked by bit 0
    } opcode_t;

    // Field view of a normal instruction
    // LDI reuses bits 7..0 as its immediate
    typedef struct packed {
        logic     is_ldi;                   // Bit 8
        opcode_t  opcode;                   // Bits 7..5
        reg_idx_t r_a;                      // Bits 4..3
        reg_idx_t r_b;                      // Bits 2..1
        logic     sel;                      // Bit 0, DONE when set under CTRL
    } instr_fields_t;

    // Fixed destination of ALU results and LDI
    localparam reg_idx_t RESULT_REG = 2'd1;

    // Run sequencing
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                      // Waiting for start
        ARMED  = 2'd1,                      // Start seen, waiting for release
        RUN    = 2'd2,                      // One instruction per clock
        HALTED = 2'd3                       // Held until reset
    } run_state_t;

    // Decoded controls, one cycle's worth
    typedef struct packed {
        logic    reg_write;                 // Register file write
        logic    mem_read;                  // LOAD, selects memory data and r_b
        logic    mem_write;                 // STORE
        logic    use_imm;                   // LDI operand path
        logic    branch;                    // BZ
        logic    done;                      // DONE
        opcode_t alu_op;                    // ALU function
    } ctrl_t;

    // All-inactive controls
    localparam ctrl_t CTRL_NOP = '{
        reg_write: 1'b0,
        mem_read:  1'b0,
        mem_write: 1'b0,
        use_imm:   1'b0,
        branch:    1'b0,
        done:      1'b0,
        alu_op:    ADD
    };

endpackage

// File: src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int unsigned MAX_CYCLES = 200,    // Cycle limit
    parameter int unsigned PROG_DEPTH = 256,    // Program words
    parameter int unsigned DMEM_DEPTH = 256     // Data words
) (
    input  logic   clk,
    input  logic   reset,                       // Async, active high
    input  logic   start,                       // Run request level
    input  logic   prog_we,                     // Program write strobe
    input  pc_t    prog_addr,                   // Program write address
    input  instr_t prog_data,                   // Program write word
    output logic   ack,                         // Halted
    output logic   timeout,                     // Halted on cycle limit
    output data_t  result                       // Register r1
);

    logic     run;                              // RUN state
    instr_t   instr;                            // Current instruction
    ctrl_t    ctrl;                             // Decoded controls
    reg_idx_t r_a;                              // Read index A
    reg_idx_t r_b;                              // Read index B
    data_t    imm;                              // LDI immediate
    pc_t      branch_offset;                    // BZ offset
    logic     branch_taken;                     // PC takes offset
    data_t    data_a;                           // Register r_a value
    data_t    data_b;                           // Register r_b value
    data_t    alu_out;                          // ALU result
    logic     write_en;                         // Register write strobe
    reg_idx_t write_reg;                        // Register destination
    data_t    write_value;                      // Register write data

    run_control #(.MAX_CYCLES(MAX_CYCLES)) i_run_control (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .done    (ctrl.done),
        .run     (run),
        .ack     (ack),
        .timeout (timeout)
    );

    fetch_unit #(.PROG_DEPTH(PROG_DEPTH)) i_fetch_unit (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .branch_taken  (branch_taken),
        .branch_offset (branch_offset),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .instr         (instr)
    );

    decode_unit i_decode_unit (
        .instr         (instr),
        .run           (run),
        .ctrl          (ctrl),
        .r_a           (r_a),
        .r_b           (r_b),
        .imm           (imm),
        .branch_offset (branch_offset)
    );

    register_file i_register_file (
        .clk         (clk),
        .reset       (reset),
        .r_a         (r_a),
        .r_b         (r_b),
        .write_en    (write_en),
        .write_reg   (write_reg),
        .write_value (write_value),
        .data_a      (data_a),
        .data_b      (data_b),
        .data_r1     (result)                   // r1 drives the result port
    );

    // Zero flag only feeds branch_taken here
    execute_unit i_execute_unit (
        .ctrl         (ctrl),
        .data_a       (data_a),
        .data_b       (data_b),
        .data_r1      (result),
        .imm          (imm),
        .alu_out      (alu_out),
        .zero         (),
        .branch_taken (branch_taken)
    );

    result_unit #(.DMEM_DEPTH(DMEM_DEPTH)) i_result_unit (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .addr        (data_a),                  // Address from r_a
        .store_data  (data_b),                  // Data from r_b
        .alu_out     (alu_out),
        .r_b         (r_b),
        .write_en    (write_en),
        .write_reg   (write_reg),
        .write_value (write_value)
    );

endmodule

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
    input  instr_t   instr,                     // Word from fetch
    input  logic     run,                       // Low forces NOP controls
    output ctrl_t    ctrl,                      // Decoded controls
    output reg_idx_t r_a,                       // First read register
    output reg_idx_t r_b,                       // Second read register
    output data_t    imm,                       // LDI immediate
    output pc_t      branch_offset              // BZ offset, sign-extended
);

    instr_fields_t fields;                      // Field view of instr
    logic          is_nop;                      // ADD r0,r0 never writes

    assign fields = instr;

    // Fields pass straight out
    assign r_a = fields.r_a;
    assign r_b = fields.r_b;
    assign imm = instr[7:0];                    // Whole low byte for LDI

    // Offset in bits 4..1, sign bit 4
    assign branch_offset = {{4{instr[4]}}, instr[4:1]};

    assign is_nop = (fields.opcode == ADD) && (fields.r_a == '0) && (fields.r_b == '0);

    always_comb begin
        ctrl = CTRL_NOP;                        // Default all inactive
        if (run) begin
            if (fields.is_ldi) begin
                ctrl.reg_write = 1'b1;          // LDI writes r1
                ctrl.use_imm   = 1'b1;          // 0 + imm
                ctrl.alu_op    = ADD;
            end else begin
                case (fields.opcode)
                    ADD, SUB, AND, XOR, SHL: begin
                        ctrl.reg_write = !is_nop;
                        ctrl.alu_op    = fields.opcode;
                    end
                    LOAD: begin
                        ctrl.reg_write = 1'b1;  // Into r_b
                        ctrl.mem_read  = 1'b1;
                    end
                    STORE: begin
                        ctrl.mem_write = 1'b1;
                    end
                    CTRL: begin
                        if (fields.sel) begin
                            ctrl.done   = 1'b1; // DONE
                        end else begin
                            ctrl.branch = 1'b1; // BZ
                            ctrl.alu_op = SUB;  // 0 - r1 for zero test
                        end
                    end
                    default: ctrl = CTRL_NOP;
                endcase
            end
        end
    end

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
    input  ctrl_t ctrl,                         // Decoded controls
    input  data_t data_a,                       // Register r_a
    input  data_t data_b,                       // Register r_b
    input  data_t data_r1,                      // Register r1
    input  data_t imm,                          // LDI immediate
    output data_t alu_out,                      // ALU result
    output logic  zero,                         // Result equals zero
    output logic  branch_taken                  // BZ condition met
);

    data_t op_a;                                // First ALU operand
    data_t op_b;                                // Second ALU operand

    // Operand selection
    always_comb begin
        if (ctrl.use_imm) begin
            op_a = '0;                          // LDI as 0 + imm
            op_b = imm;
        end else if (ctrl.branch) begin
            op_a = '0;                          // 0 - r1
            op_b = data_r1;
        end else begin
            op_a = data_a;
            op_b = data_b;
        end
    end

    // ALU
    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            XOR:     alu_out = op_a ^ op_b;
            SHL:     alu_out = op_a << op_b[2:0];   // Shift 0..7
            default: alu_out = op_a + op_b;         // Result unused
        endcase
    end

    // Zero flag
    // For BZ this is r1 == 0
    assign zero = (alu_out == '0);

    assign branch_taken = ctrl.branch & zero;

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
    parameter int unsigned PROG_DEPTH = 256     // Program words
) (
    input  logic   clk,
    input  logic   reset,                       // Async, active high
    input  logic   run,                         // PC advances only while high
    input  logic   branch_taken,                // BZ with r1 == 0
    input  pc_t    branch_offset,               // Sign-extended offset
    input  logic   prog_we,                     // Load strobe, idle only
    input  pc_t    prog_addr,                   // Load address
    input  instr_t prog_data,                   // Load word
    output instr_t instr                        // Word at current PC
);

    instr_t prog_mem [PROG_DEPTH];              // Program storage
    pc_t    pc;                                 // Program counter
    pc_t    pc_step;                            // Amount added this cycle
    pc_t    pc_next;                            // PC after this instruction

    // Branch target selection
    always_comb begin
        if (branch_taken) begin
            pc_step = branch_offset;            // Relative jump, may be backward
        end else begin
            pc_step = pc_t'(1);                 // Sequential
        end
        pc_next = pc + pc_step;                 // Wraps at 256
    end

    // Program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;                           // First instruction at 0
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // Load port into program memory
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;   // One word per strobe
        end
    end

    // Asynchronous read
    // Instruction is ready in the same cycle as the PC
    assign instr = prog_mem[pc];

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,                     // Async, clears all registers
    input  reg_idx_t r_a,                       // Read port A index
    input  reg_idx_t r_b,                       // Read port B index
    input  logic     write_en,                  // Write strobe
    input  reg_idx_t write_reg,                 // Destination
    input  data_t    write_value,               // Value written
    output data_t    data_a,                    // Port A data
    output data_t    data_b,                    // Port B data
    output data_t    data_r1                    // r1, always visible
);

    data_t regs [4];                            // r0..r3

    // Single write port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_reg] <= write_value;
        end
    end

    // Asynchronous reads
    assign data_a = regs[r_a];
    assign data_b = regs[r_b];

    // Branch test and result port
    assign data_r1 = regs[RESULT_REG];

endmodule

// File: src/result_unit.sv
`timescale 1ns/1ps

module result_unit import cpu_pkg::*; #(
    parameter int unsigned DMEM_DEPTH = 256     // Data words
) (
    input  logic     clk,
    input  logic     reset,                     // Async, clears data memory
    input  ctrl_t    ctrl,                      // Decoded controls
    input  data_t    addr,                      // Memory address from r_a
    input  data_t    store_data,                // STORE data from r_b
    input  data_t    alu_out,                   // ALU result
    input  reg_idx_t r_b,                       // LOAD destination
    output logic     write_en,                  // Register write strobe
    output reg_idx_t write_reg,                 // Register destination
    output data_t    write_value                // Register write data
);

    data_t dmem [DMEM_DEPTH];                   // Data storage
    data_t mem_data;                            // Read data

    // Starts at zero, no load port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.mem_write) begin
            dmem[addr] <= store_data;           // STORE
        end
    end

    // Asynchronous read
    assign mem_data = dmem[addr];

    // Write-back selection
    always_comb begin
        write_en = ctrl.reg_write;
        if (ctrl.mem_read) begin
            write_reg   = r_b;                  // LOAD target
            write_value = mem_data;
        end else begin
            write_reg   = RESULT_REG;           // ALU ops and LDI
            write_value = alu_out;
        end
    end

endmodule

// File: src/run_control.sv
`timescale 1ns/1ps

module run_control import cpu_pkg::*; #(
    parameter int unsigned MAX_CYCLES = 200     // RUN cycles before timeout
) (
    input  logic clk,
    input  logic reset,                         // Async, back to IDLE
    input  logic start,                         // Level from testbench
    input  logic done,                          // DONE decoded this cycle
    output logic run,                           // High in RUN only
    output logic ack,                           // Held once halted
    output logic timeout                        // Halt came from the limit
);

    localparam int CNT_W = (MAX_CYCLES > 1) ? $clog2(MAX_CYCLES) : 1;

    run_state_t       state;                    // Sequencing FSM
    logic [CNT_W-1:0] cycle_count;              // Completed RUN cycles
    logic             limit_hit;                // Last allowed cycle

    assign limit_hit = (cycle_count == CNT_W'(MAX_CYCLES - 1));
    assign run       = (state == RUN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            cycle_count <= '0;
            ack         <= 1'b0;
            timeout     <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) state <= ARMED;    // Start raised
                ARMED: if (!start) state <= RUN;    // First edge with start low
                RUN: begin
                    cycle_count <= cycle_count + 1'b1;
                    if (done) begin
                        ack   <= 1'b1;              // DONE wins over limit
                        state <= HALTED;
                    end else if (limit_hit) begin
                        ack     <= 1'b1;
                        timeout <= 1'b1;
                        state   <= HALTED;
                    end
                end
                default: state <= HALTED;           // Hold until reset
            endcase
        end
    end

endmodule
